/* Makefile */
# Verilator build and run of the memory exerciser testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_test
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= >>> PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -Fqx -- '$(PASS_TEXT)' $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/expect_fifo.sv */
// Depth must be a power of two; pushes never exceed the credits handed out, so there is no full flag
`timescale 1ns/1ps

module expect_fifo
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    exp_push,
    input  mem_test_pkg::mem_data_t exp_data,
    input  logic                    exp_pop,
    output mem_test_pkg::mem_data_t exp_head,
    output logic                    exp_empty,
    output logic                    credit_return
);
    import mem_test_pkg::*;

    mem_data_t                       entries [EXPECT_DEPTH];
    logic [$clog2(EXPECT_DEPTH)-1:0] wr_ptr;
    logic [$clog2(EXPECT_DEPTH)-1:0] rd_ptr;
    credit_t                         fill;
    logic                            do_pop;

    // Pop of an empty queue is dropped here and flagged by the checker
    assign do_pop = exp_pop && !exp_empty;
    assign exp_empty = (fill == credit_t'(0));
    assign exp_head = entries[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (exp_push)
        begin
            entries[wr_ptr] <= exp_data;
        end
    end

    // Pointers wrap on their own
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill <= '0;
            credit_return <= 1'b0;
        end
        else
        begin
            wr_ptr <= wr_ptr + exp_push;
            rd_ptr <= rd_ptr + do_pop;
            fill <= fill + credit_t'(exp_push) - credit_t'(do_pop);
            // One credit back to the generator per entry removed
            credit_return <= do_pop;
        end
    end

endmodule

/* design/mem_test_pkg.sv */
// Shared widths and types; the memory is 256 words of 32 bits and the expected-value queue holds 16
package mem_test_pkg;

    // ========================================================================
    // Memory geometry
    // ========================================================================

    localparam int MEM_ADDR_BITS = 8;
    localparam int MEM_DATA_BITS = 32;

    typedef logic [MEM_ADDR_BITS-1:0] mem_addr_t;
    // Whole data word doubles as the tag kept in the shadow RAM
    typedef logic [MEM_DATA_BITS-1:0] mem_data_t;

    // Run counters and run length
    typedef logic [15:0] count_t;

    // Queue depth is also the starting credit count
    localparam int EXPECT_DEPTH = 16;
    typedef logic [$clog2(EXPECT_DEPTH+1)-1:0] credit_t;

    // Latencies in cycles
    localparam int SHADOW_RD_LATENCY = 2;
    localparam int MIN_RSP_LATENCY = 4;

    // ========================================================================
    // Random sources
    // ========================================================================

    // Galois mask for x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    // Seeds must be nonzero or the LFSR locks up
    localparam logic [31:0] RD_LFSR_SEED = 32'h0000_2721;
    localparam logic [31:0] WR_LFSR_SEED = 32'h0000_8520;
    localparam logic [31:0] DATA_LFSR_SEED = 32'h1357_9bdf;

    // ========================================================================
    // Bundles
    // ========================================================================

    typedef struct packed {
        count_t run_cycles;
        logic   enable_reads;
        logic   enable_writes;
        logic   enable_rw_conflicts;
    } run_cfg_t;

    typedef struct packed {
        logic      valid;
        mem_addr_t addr;
        mem_data_t data;
    } mem_wr_req_t;

    typedef struct packed {
        logic      valid;
        mem_addr_t addr;
    } mem_rd_req_t;

    typedef struct packed {
        logic      valid;
        mem_data_t data;
    } mem_rd_rsp_t;

    typedef struct packed {
        logic   busy;
        logic   done;
        logic   error;
        count_t rd_rsp_count;
        count_t wr_count;
        count_t checked_count;
    } run_status_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } run_state_t;

endpackage

/* design/mem_test_top.sv */
// Responses must return in request order and no sooner than MIN_RSP_LATENCY cycles after the read
`timescale 1ns/1ps

module mem_test_top
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  mem_test_pkg::run_cfg_t    cfg,
    input  logic                      mem_stall,
    output mem_test_pkg::mem_wr_req_t wr_req,
    output mem_test_pkg::mem_rd_req_t rd_req,
    input  mem_test_pkg::mem_rd_rsp_t rd_rsp,
    output mem_test_pkg::run_status_t status
);
    import mem_test_pkg::*;

    // Run control to generator
    logic     run_active;
    run_cfg_t cfg_q;
    logic     run_start;
    logic     busy;
    logic     done;

    // Credit loop and shadow lookups
    logic      ready;
    logic      all_credits_home;
    logic      credit_return;
    logic      exp_push;
    mem_data_t exp_data;
    logic      exp_pop;
    mem_data_t exp_head;
    logic      exp_empty;

    // Checker results
    logic   error;
    count_t rd_rsp_count;
    count_t wr_count;
    count_t checked_count;

    run_control run_control_inst
    (
        .clk, .reset, .start, .cfg, .ready, .all_credits_home, .error,
        .run_active, .cfg_q, .run_start, .busy, .done
    );

    req_generator req_generator_inst
    (
        .clk, .reset, .run_active, .cfg_q, .mem_stall, .credit_return,
        .wr_req, .rd_req, .all_credits_home
    );

    shadow_ram shadow_ram_inst
    (
        .clk, .reset, .wr_req, .rd_req, .ready, .exp_push, .exp_data
    );

    expect_fifo expect_fifo_inst
    (
        .clk, .reset, .exp_push, .exp_data, .exp_pop, .exp_head, .exp_empty,
        .credit_return
    );

    rsp_checker rsp_checker_inst
    (
        .clk, .reset, .run_start, .rd_rsp, .wr_req, .exp_head, .exp_empty,
        .exp_pop, .error, .rd_rsp_count, .wr_count, .checked_count
    );

    // Status assembled from run control and checker fields
    always_comb
    begin
        status.busy = busy;
        status.done = done;
        status.error = error;
        status.rd_rsp_count = rd_rsp_count;
        status.wr_count = wr_count;
        status.checked_count = checked_count;
    end

endmodule

/* design/req_generator.sv */
// Valid bits are gated by mem_stall in the same cycle; reads need a credit, the queue never overflows
`timescale 1ns/1ps

module req_generator
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      run_active,
    input  mem_test_pkg::run_cfg_t    cfg_q,
    input  logic                      mem_stall,
    input  logic                      credit_return,
    output mem_test_pkg::mem_wr_req_t wr_req,
    output mem_test_pkg::mem_rd_req_t rd_req,
    output logic                      all_credits_home
);
    import mem_test_pkg::*;

    logic [31:0] rd_lfsr;
    logic [31:0] wr_lfsr;
    logic [31:0] data_lfsr;
    mem_addr_t   rd_addr;
    mem_addr_t   wr_addr;
    credit_t     credits;
    logic        rd_go;
    logic        wr_go;

    // One Galois shift to the right
    function automatic logic [31:0] lfsr_step(logic [31:0] v);
        logic [31:0] n;
        n = {1'b0, v[31:1]};
        if (v[0])
        begin
            n = n ^ LFSR_TAPS;
        end
        return n;
    endfunction

    // ========================================================================
    // Random sources, stepped every cycle whether or not a request leaves
    // ========================================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_lfsr <= RD_LFSR_SEED;
            wr_lfsr <= WR_LFSR_SEED;
            data_lfsr <= DATA_LFSR_SEED;
        end
        else
        begin
            rd_lfsr <= lfsr_step(rd_lfsr);
            wr_lfsr <= lfsr_step(wr_lfsr);
            data_lfsr <= lfsr_step(data_lfsr);
        end
    end

    always_comb
    begin
        rd_addr = rd_lfsr[MEM_ADDR_BITS-1:0];
        wr_addr = wr_lfsr[MEM_ADDR_BITS-1:0];
        // Without conflicts, reads use even words and writes odd words
        if (!cfg_q.enable_rw_conflicts)
        begin
            rd_addr[0] = 1'b0;
            wr_addr[0] = 1'b1;
        end
    end

    // ========================================================================
    // Issue rules and credits
    // ========================================================================

    assign wr_go = run_active && cfg_q.enable_writes && !mem_stall;
    assign rd_go = run_active && cfg_q.enable_reads && !mem_stall &&
                   (credits != credit_t'(0));

    always_comb
    begin
        wr_req.valid = wr_go;
        wr_req.addr = wr_addr;
        wr_req.data = data_lfsr;
        rd_req.valid = rd_go;
        rd_req.addr = rd_addr;
    end

    // A read spends one credit, each queue pop returns one
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            credits <= credit_t'(EXPECT_DEPTH);
        end
        else
        begin
            credits <= credits + credit_t'(credit_return) - credit_t'(rd_go);
        end
    end

    assign all_credits_home = (credits == credit_t'(EXPECT_DEPTH));

endmodule

/* design/rsp_checker.sv */
// Responses are matched to the queue head in order; counters lag their events by two cycles
`timescale 1ns/1ps

module rsp_checker
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      run_start,
    input  mem_test_pkg::mem_rd_rsp_t rd_rsp,
    input  mem_test_pkg::mem_wr_req_t wr_req,
    input  mem_test_pkg::mem_data_t   exp_head,
    input  logic                      exp_empty,
    output logic                      exp_pop,
    output logic                      error,
    output mem_test_pkg::count_t      rd_rsp_count,
    output mem_test_pkg::count_t      wr_count,
    output mem_test_pkg::count_t      checked_count
);
    import mem_test_pkg::*;

    logic mismatch;
    logic rsp_q;
    logic wr_q;
    logic match_q;

    // Compare in the arrival cycle; a response with nothing queued is an error too
    assign exp_pop = rd_rsp.valid && !exp_empty;
    assign mismatch = rd_rsp.valid && (exp_empty || (rd_rsp.data != exp_head));

    // Event flags, so a write in the clearing cycle still gets counted
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp_q <= 1'b0;
            wr_q <= 1'b0;
            match_q <= 1'b0;
        end
        else
        begin
            rsp_q <= rd_rsp.valid;
            wr_q <= wr_req.valid;
            match_q <= exp_pop && !mismatch;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset || run_start)
        begin
            rd_rsp_count <= '0;
            wr_count <= '0;
            checked_count <= '0;
            error <= 1'b0;
        end
        else
        begin
            rd_rsp_count <= rd_rsp_count + count_t'(rsp_q);
            wr_count <= wr_count + count_t'(wr_q);
            checked_count <= checked_count + count_t'(match_q);
            // Sticky until the next run
            if (mismatch)
            begin
                error <= 1'b1;
            end
        end
    end

endmodule

/* design/run_control.sv */
// A start is ignored unless the shadow RAM is ready and no run is in progress
`timescale 1ns/1ps

module run_control
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  mem_test_pkg::run_cfg_t cfg,
    input  logic                   ready,
    input  logic                   all_credits_home,
    input  logic                   error,
    output logic                   run_active,
    output mem_test_pkg::run_cfg_t cfg_q,
    output logic                   run_start,
    output logic                   busy,
    output logic                   done
);
    import mem_test_pkg::*;

    run_state_t state;
    count_t     cycles_rem;
    logic       accept;

    assign accept = start && ready && (state == IDLE);
    // Requests may leave only in the RUN window
    assign run_active = (state == RUN);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
            cfg_q <= '0;
            cycles_rem <= '0;
            run_start <= 1'b0;
            busy <= 1'b0;
            done <= 1'b0;
        end
        else
        begin
            // Clears the checker one cycle after the accepted start
            run_start <= accept;

            case (state)
                IDLE:
                begin
                    if (accept)
                    begin
                        cfg_q <= cfg;
                        cycles_rem <= cfg.run_cycles;
                        busy <= 1'b1;
                        done <= 1'b0;
                        // Zero-length run goes straight to the drain
                        state <= (cfg.run_cycles == '0) ? DRAIN : RUN;
                    end
                end

                RUN:
                begin
                    cycles_rem <= cycles_rem - count_t'(1);
                    // Old error is still visible while run_start clears it
                    if ((cycles_rem == count_t'(1)) || (error && !run_start))
                    begin
                        state <= DRAIN;
                    end
                end

                default:
                begin
                    // Wait for every outstanding read to come back
                    if (all_credits_home)
                    begin
                        state <= IDLE;
                        busy <= 1'b0;
                        done <= 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

/* design/shadow_ram.sv */
// Requests before ready are not allowed; a read that meets a write to its address sees old data
`timescale 1ns/1ps

module shadow_ram
(
    input  logic                      clk,
    input  logic                      reset,
    input  mem_test_pkg::mem_wr_req_t wr_req,
    input  mem_test_pkg::mem_rd_req_t rd_req,
    output logic                      ready,
    output logic                      exp_push,
    output mem_test_pkg::mem_data_t   exp_data
);
    import mem_test_pkg::*;

    mem_data_t mem [2**MEM_ADDR_BITS];
    mem_addr_t clr_addr;

    // Read pipeline, stage 0 is the array output register
    mem_data_t                    rd_pipe [SHADOW_RD_LATENCY];
    logic [SHADOW_RD_LATENCY-1:0] vld_pipe;

    // Clear sweep, one word per cycle after reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            clr_addr <= '0;
            ready <= 1'b0;
        end
        else if (!ready)
        begin
            clr_addr <= clr_addr + mem_addr_t'(1);
            ready <= (clr_addr == '1);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!ready)
        begin
            mem[clr_addr] <= '0;
        end
        else if (wr_req.valid)
        begin
            mem[wr_req.addr] <= wr_req.data;
        end

        // Nonblocking read of the same edge gives the old-data rule
        rd_pipe[0] <= mem[rd_req.addr];
        for (int i = 1; i < SHADOW_RD_LATENCY; i++)
        begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            vld_pipe <= '0;
        end
        else
        begin
            vld_pipe <= {vld_pipe[SHADOW_RD_LATENCY-2:0], rd_req.valid};
        end
    end

    assign exp_push = vld_pipe[SHADOW_RD_LATENCY-1];
    assign exp_data = rd_pipe[SHADOW_RD_LATENCY-1];

endmodule

/* filelist.f */
design/mem_test_pkg.sv
design/run_control.sv
design/req_generator.sv
design/shadow_ram.sv
design/expect_fifo.sv
design/rsp_checker.sv
design/mem_test_top.sv
test/mem_test_assert.sv
test/tb_mem_test.sv

/* test/mem_test_assert.sv */
// Bound into req_generator; observes its ports and credit counter at each rising edge
`timescale 1ns/1ps

module mem_test_assert
(
    input logic                      clk,
    input logic                      reset,
    input logic                      mem_stall,
    input mem_test_pkg::mem_wr_req_t wr_req,
    input mem_test_pkg::mem_rd_req_t rd_req,
    input mem_test_pkg::credit_t     credits
);
    import mem_test_pkg::*;

    // A read always consumes a held credit
    read_needs_credit: assert property (@(posedge clk) disable iff (reset)
        rd_req.valid |-> (credits != credit_t'(0)))
        else $error("Read issued with zero credits");

    // Back-pressure holds both request kinds
    stall_blocks_requests: assert property (@(posedge clk) disable iff (reset)
        mem_stall |-> !(rd_req.valid || wr_req.valid))
        else $error("Request issued while mem_stall high");

    credits_bounded: assert property (@(posedge clk) disable iff (reset)
        credits <= credit_t'(EXPECT_DEPTH))
        else $error("Credit count above queue depth");

endmodule

bind req_generator mem_test_assert mem_test_assert_inst
(
    .clk, .reset, .mem_stall, .wr_req, .rd_req, .credits
);

/* test/tb_mem_test.sv */
// Memory model keeps order and returns reads 4 to 7 cycles late; the run table fixes every scenario
`timescale 1ns/1ps

module tb_mem_test;
    import mem_test_pkg::*;

    // ========================================================================
    // DUT connections
    // ========================================================================

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        start = 1'b0;
    run_cfg_t    cfg = '0;
    logic        mem_stall = 1'b0;
    mem_wr_req_t wr_req;
    mem_rd_req_t rd_req;
    mem_rd_rsp_t rd_rsp = '0;
    run_status_t status;

    // One row per run
    typedef struct packed {
        count_t run_cycles;
        logic   enable_reads;
        logic   enable_writes;
        logic   enable_rw_conflicts;
        int     stall_pct;
        int     corrupt_idx;
        logic   exp_error;
        logic   restart;
    } row_t;

    // Cycles, rd, wr, conflicts, stall %, corrupt index, error, restart while busy
    row_t table_rows [6] = '{
        '{16'd60, 1'b1, 1'b0, 1'b0, 0, -1, 1'b0, 1'b0},
        '{16'd60, 1'b0, 1'b1, 1'b0, 0, -1, 1'b0, 1'b0},
        '{16'd200, 1'b1, 1'b1, 1'b0, 30, -1, 1'b0, 1'b0},
        '{16'd4000, 1'b1, 1'b1, 1'b1, 10, -1, 1'b0, 1'b0},
        '{16'd120, 1'b1, 1'b1, 1'b0, 20, 5, 1'b1, 1'b0},
        '{16'd40, 1'b1, 1'b1, 1'b0, 0, -1, 1'b0, 1'b1}
    };

    // Memory model state, written only by the model process
    mem_data_t model_mem [2**MEM_ADDR_BITS];
    mem_data_t pend_data [$];
    int        pend_cycle [$];
    int        edge_count;
    int        head_due;
    bit        head_timed;
    int        last_due;
    int        reads_seen;
    int        writes_seen;
    int        rsps_sent;
    int        conflicts_seen;

    // Run knobs, written only by the main sequence
    int stall_pct = 0;
    int corrupt_at = -1;

    mem_test_top mem_test_top_inst
    (
        .clk, .reset, .start, .cfg, .mem_stall, .wr_req, .rd_req, .rd_rsp, .status
    );

    always #2 clk = ~clk;

    // ========================================================================
    // Checks
    // ========================================================================

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected)
        begin
            stop_with_failure($sformatf("MISMATCH at %0t ns: %s got %b expected %b",
                                        $time, what, actual, expected));
        end
    endtask

    task automatic check_count(input count_t actual, input count_t expected,
                               input string what);
        if (actual !== expected)
        begin
            stop_with_failure($sformatf("MISMATCH at %0t ns: %s got %0d expected %0d",
                                        $time, what, actual, expected));
        end
    endtask

    // ========================================================================
    // Memory model
    // ========================================================================

    always
    begin
        @(posedge clk);
        if (reset)
        begin
            // Same zero contents as the shadow RAM after its sweep
            for (int i = 0; i < 2**MEM_ADDR_BITS; i++)
            begin
                model_mem[i] = '0;
            end
            pend_data.delete();
            pend_cycle.delete();
            edge_count = 0;
            head_timed = 1'b0;
            last_due = 0;
            reads_seen = 0;
            writes_seen = 0;
            rsps_sent = 0;
            conflicts_seen = 0;
        end
        else
        begin
            edge_count = edge_count + 1;
            if (mem_stall)
            begin
                check_flag(wr_req.valid || rd_req.valid, 1'b0, "request while mem_stall high");
            end
            check_flag(mem_test_top_inst.req_generator_inst.credits <= EXPECT_DEPTH, 1'b1,
                       "credits above queue depth");
            if (rd_req.valid)
            begin
                check_flag(mem_test_top_inst.req_generator_inst.credits != 0, 1'b1,
                           "read issued without credit");
                // Reads stay on even words unless conflicts are enabled
                if (!cfg.enable_rw_conflicts)
                begin
                    check_flag(rd_req.addr[0], 1'b0, "read address bit 0 without conflicts");
                end
                // Read first, so a same-cycle write leaves the old word
                pend_data.push_back(model_mem[rd_req.addr]);
                pend_cycle.push_back(edge_count);
                reads_seen = reads_seen + 1;
                if (wr_req.valid && (wr_req.addr == rd_req.addr))
                begin
                    conflicts_seen = conflicts_seen + 1;
                end
            end
            if (wr_req.valid)
            begin
                // Writes stay on odd words unless conflicts are enabled
                if (!cfg.enable_rw_conflicts)
                begin
                    check_flag(wr_req.addr[0], 1'b1, "write address bit 0 without conflicts");
                end
                model_mem[wr_req.addr] = wr_req.data;
                writes_seen = writes_seen + 1;
            end
        end

        @(negedge clk);
        rd_rsp = '0;
        if (!reset)
        begin
            mem_stall = (int'($urandom_range(99)) < stall_pct);
            if ((pend_cycle.size() > 0) && !head_timed)
            begin
                // Random extra delay, never earlier than the previous response
                head_due = pend_cycle[0] + MIN_RSP_LATENCY + int'($urandom_range(3));
                if (head_due <= last_due)
                begin
                    head_due = last_due + 1;
                end
                head_timed = 1'b1;
            end
            if (head_timed && (head_due == edge_count + 1))
            begin
                rd_rsp.valid = 1'b1;
                rd_rsp.data = pend_data.pop_front();
                void'(pend_cycle.pop_front());
                if (rsps_sent == corrupt_at)
                begin
                    rd_rsp.data = rd_rsp.data ^ 32'h0000_0001;
                end
                last_due = head_due;
                head_timed = 1'b0;
                rsps_sent = rsps_sent + 1;
            end
        end
    end

    // ========================================================================
    // Run sequence
    // ========================================================================

    task automatic wait_ready(input int limit);
        int n;
        n = 0;
        while (!mem_test_top_inst.shadow_ram_inst.ready)
        begin
            if (n == limit)
            begin
                stop_with_failure("Timeout: shadow RAM never became ready");
            end
            else
            begin
                n = n + 1;
                @(negedge clk);
            end
        end
    endtask

    task automatic wait_done(input int limit);
        int n;
        n = 0;
        while (!status.done)
        begin
            if (n == limit)
            begin
                stop_with_failure("Timeout: run did not finish");
            end
            else
            begin
                n = n + 1;
                @(negedge clk);
            end
        end
    endtask

    task automatic run_row(input row_t row);
        int rd_base;
        int wr_base;
        int rsp_base;
        int cf_base;
        int reads;
        int writes;
        int pairs;
        rd_base = reads_seen;
        wr_base = writes_seen;
        rsp_base = rsps_sent;
        cf_base = conflicts_seen;
        wait_ready(400);
        stall_pct = row.stall_pct;
        corrupt_at = (row.corrupt_idx < 0) ? -1 : rsps_sent + row.corrupt_idx;
        cfg.run_cycles = row.run_cycles;
        cfg.enable_reads = row.enable_reads;
        cfg.enable_writes = row.enable_writes;
        cfg.enable_rw_conflicts = row.enable_rw_conflicts;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_flag(status.busy, 1'b1, "busy one cycle after start");
        @(negedge clk);
        // Previous results cleared together
        check_flag(status.done, 1'b0, "done cleared by start");
        check_flag(status.error, 1'b0, "error cleared by start");
        check_count(status.rd_rsp_count, '0, "response count cleared");
        check_count(status.wr_count, '0, "write count cleared");
        check_count(status.checked_count, '0, "checked count cleared");

        // Second start lands in RUN and must change nothing
        if (row.restart)
        begin
            repeat (3) @(negedge clk);
            cfg.run_cycles = 16'd5;
            cfg.enable_writes = 1'b0;
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
        end

        wait_done(int'(row.run_cycles) + 3000);
        stall_pct = 0;
        reads = reads_seen - rd_base;
        writes = writes_seen - wr_base;
        pairs = conflicts_seen - cf_base;
        check_flag(status.busy, 1'b0, "busy low at done");
        check_flag(status.error, row.exp_error, "error flag at done");
        check_count(count_t'(rsps_sent - rsp_base), count_t'(reads), "responses returned");
        check_count(status.rd_rsp_count, count_t'(reads), "response count");
        check_count(status.wr_count, count_t'(writes), "write count");
        if (row.exp_error)
        begin
            check_count(status.checked_count, count_t'(reads - 1),
                        "checked count with one bad response");
        end
        else
        begin
            check_count(status.checked_count, count_t'(reads), "checked count");
        end
        // No stall means one write in every cycle of the window
        if ((row.stall_pct == 0) && row.enable_writes && !row.exp_error)
        begin
            check_count(status.wr_count, row.run_cycles, "writes over the run window");
        end
        // A conflict run has to meet the old-data rule at least once
        if (row.enable_rw_conflicts && row.enable_reads && row.enable_writes)
        begin
            check_flag(pairs > 0, 1'b1, "same-address pairs in a conflict run");
        end
        if (row.restart)
        begin
            repeat (5) @(negedge clk);
            check_flag(status.busy, 1'b0, "no run started by the ignored start");
            check_flag(status.done, 1'b1, "done held after the first run");
        end
        $display("Run: %0d reads, %0d writes, %0d same-address pairs", reads, writes,
                 pairs);
    endtask

    initial
    begin
        void'($urandom(58238));
        repeat (8) @(negedge clk);
        reset = 1'b0;
        for (int r = 0; r < $size(table_rows); r++)
        begin
            run_row(table_rows[r]);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule
